//--- source/cache_pkg.sv
// Shared geometry, encodings and channel types for the two-way write-through data cache
package cache_pkg;

    // Geometry
    localparam int addr_w = 32;
    localparam int ways = 2;
    localparam int ways_w = 1;
    localparam int lanes_w = 2;
    localparam int offset_w = 4;
    localparam int tag_w = addr_w - lanes_w - offset_w - 2;
    localparam logic [7:0] refill_len = 8'd15;
    localparam int cacheable_bit = 31;

    typedef enum logic [2:0] {
        cmd_none,
        cmd_load,
        cmd_execute,
        cmd_store,
        cmd_flush_all
    } cache_cmd_e;

    typedef enum logic [2:0] {
        resp_idle,
        resp_wait,
        resp_done,
        resp_misaligned,
        resp_unknown_type,
        resp_access_fault
    } cache_resp_e;

    // Codes 5..7 are reported as unknown type
    typedef enum logic [2:0] {
        load_lb,
        load_lbu,
        load_lh,
        load_lhu,
        load_lw
    } load_type_e;

    typedef enum logic [1:0] {
        store_sb,
        store_sh,
        store_sw
    } store_type_e;

    typedef enum logic [1:0] {
        axi_okay,
        axi_exokay,
        axi_slverr,
        axi_decerr
    } axi_resp_e;

    typedef struct packed {
        cache_cmd_e cmd;
        logic [addr_w-1:0] address;
        load_type_e load_type;
        store_type_e store_type;
        logic [31:0] store_data;
    } cache_req_t;

    // Memory side channels, INCR bursts only
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [7:0] len;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        axi_resp_e resp;
        logic last;
    } axi_r_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0] strb;
    } axi_w_t;

    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

endpackage

//--- source/cache_tag_store.sv
// Tag memory and valid bits for every way, with hit detection for the output stage
`timescale 1ns/1ps

module cache_tag_store (
    input logic clk,
    input logic rst_n,
    input logic tag_read,
    input logic [cache_pkg::lanes_w-1:0] lane,
    input logic tag_write,
    input logic [cache_pkg::ways_w-1:0] tag_write_way,
    input logic [cache_pkg::tag_w-1:0] os_tag,
    input logic invalidate_all,
    output logic hit,
    output logic [cache_pkg::ways_w-1:0] hit_way
);
    import cache_pkg::*;

    logic [tag_w-1:0] tags [ways][1 << lanes_w];
    logic [tag_w-1:0] tag_q [ways];
    logic [lanes_w-1:0] lane_q;
    logic [(1 << lanes_w)-1:0] valid [ways];

    always_ff @(posedge clk) begin
        if (tag_read) begin
            lane_q <= lane;
            for (int w = 0; w < ways; w++) begin
                tag_q[w] <= tags[w][lane];
            end
        end
        if (tag_write) begin
            tags[tag_write_way][lane] <= os_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < ways; w++) begin
                valid[w] <= '0;
            end
        end else if (invalidate_all) begin
            for (int w = 0; w < ways; w++) begin
                valid[w] <= '0;
            end
        end else if (tag_write) begin
            valid[tag_write_way][lane] <= 1'b1;
        end
    end

    // Live valid bits, so a flush is seen by the very next lookup
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < ways; w++) begin
            if (valid[w][lane_q] && tag_q[w] == os_tag) begin
                hit = 1'b1;
                hit_way = ways_w'(w);
            end
        end
    end

endmodule

//--- source/cache_data_store.sv
// Word storage for every way with byte-enabled writes and a registered read
`timescale 1ns/1ps

module cache_data_store (
    input logic clk,
    input logic data_read,
    input logic [cache_pkg::lanes_w-1:0] data_lane,
    input logic [cache_pkg::offset_w-1:0] data_offset,
    input logic data_write,
    input logic [cache_pkg::ways_w-1:0] data_way,
    input logic [31:0] data_wdata,
    input logic [3:0] data_strb,
    input logic [cache_pkg::ways_w-1:0] hit_way,
    output logic [31:0] hit_rdata
);
    import cache_pkg::*;

    logic [31:0] mem [ways][1 << (lanes_w + offset_w)];
    logic [31:0] rdata [ways];
    logic [lanes_w+offset_w-1:0] addr;

    assign addr = {data_lane, data_offset};

    always_ff @(posedge clk) begin
        for (int w = 0; w < ways; w++) begin
            if (data_read) begin
                rdata[w] <= mem[w][addr];
            end
            if (data_write && data_way == ways_w'(w)) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_strb[b]) begin
                        mem[w][addr][8*b +: 8] <= data_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // All ways are read, the tag compare picks one
    assign hit_rdata = rdata[hit_way];

endmodule

//--- source/cache_load_align.sv
// Load alignment: picks the byte or half, extends it and flags bad accesses
`timescale 1ns/1ps

module cache_load_align (
    input logic [1:0] os_inword,
    input cache_pkg::load_type_e os_load_type,
    input logic [31:0] load_word,
    output logic [31:0] c_load_data,
    output logic [1:0] load_fault
);
    import cache_pkg::*;

    logic [7:0] sel_byte;
    logic [15:0] sel_half;

    assign sel_byte = load_word[{os_inword, 3'b000} +: 8];
    assign sel_half = load_word[{os_inword[1], 4'b0000} +: 16];

    // load_fault is {misaligned, unknown}
    always_comb begin
        load_fault = 2'b00;
        c_load_data = load_word;
        case (os_load_type)
            load_lb: c_load_data = {{24{sel_byte[7]}}, sel_byte};
            load_lbu: c_load_data = {24'h0, sel_byte};
            load_lh: begin
                c_load_data = {{16{sel_half[15]}}, sel_half};
                load_fault[1] = os_inword[0];
            end
            load_lhu: begin
                c_load_data = {16'h0, sel_half};
                load_fault[1] = os_inword[0];
            end
            load_lw: load_fault[1] = |os_inword;
            default: load_fault[0] = 1'b1;
        endcase
    end

endmodule

//--- source/cache_store_align.sv
// Store alignment: replicates data into its lanes, builds the strobe, flags bad accesses
`timescale 1ns/1ps

module cache_store_align (
    input logic [1:0] os_inword,
    input cache_pkg::store_type_e os_store_type,
    input logic [31:0] os_store_data,
    output logic [31:0] store_data,
    output logic [3:0] store_strb,
    output logic [1:0] store_fault
);
    import cache_pkg::*;

    always_comb begin
        store_fault = 2'b00;
        store_data = os_store_data;
        store_strb = 4'b0000;
        case (os_store_type)
            store_sb: begin
                store_data = {4{os_store_data[7:0]}};
                store_strb = 4'b0001 << os_inword;
            end
            store_sh: begin
                store_data = {2{os_store_data[15:0]}};
                store_strb = os_inword[1] ? 4'b1100 : 4'b0011;
                store_fault[1] = os_inword[0];
            end
            store_sw: begin
                store_strb = 4'b1111;
                store_fault[1] = |os_inword;
            end
            default: store_fault[0] = 1'b1;
        endcase
    end

endmodule

//--- source/cache_controller.sv
// Cache control: output-stage registers and the FSM for lookup, refill, bypass and write-through
`timescale 1ns/1ps

module cache_controller (
    input logic clk,
    input logic rst_n,
    input cache_pkg::cache_req_t c_req,
    output cache_pkg::cache_resp_e c_resp,
    output logic ar_valid,
    input logic ar_ready,
    output cache_pkg::axi_ar_t ar,
    input logic r_valid,
    output logic r_ready,
    input cache_pkg::axi_r_t r,
    output logic aw_valid,
    input logic aw_ready,
    output cache_pkg::axi_aw_t aw,
    output logic w_valid,
    input logic w_ready,
    output cache_pkg::axi_w_t w,
    input logic b_valid,
    output logic b_ready,
    input cache_pkg::axi_b_t b,
    output logic tag_read,
    output logic [cache_pkg::lanes_w-1:0] lane,
    output logic [cache_pkg::ways_w-1:0] tag_write_way,
    output logic tag_write,
    output logic [cache_pkg::tag_w-1:0] os_tag,
    output logic invalidate_all,
    input logic hit,
    input logic [cache_pkg::ways_w-1:0] hit_way,
    output logic data_read,
    output logic [cache_pkg::lanes_w-1:0] data_lane,
    output logic [cache_pkg::offset_w-1:0] data_offset,
    output logic data_write,
    output logic [cache_pkg::ways_w-1:0] data_way,
    output logic [31:0] data_wdata,
    output logic [3:0] data_strb,
    input logic [31:0] hit_rdata,
    output logic [1:0] os_inword,
    output cache_pkg::load_type_e os_load_type,
    output cache_pkg::store_type_e os_store_type,
    output logic [31:0] os_store_data,
    input logic [1:0] load_fault,
    input logic [31:0] store_data,
    input logic [3:0] store_strb,
    input logic [1:0] store_fault,
    output logic [31:0] load_word
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_refill,
        st_replay,
        st_bypass_read,
        st_write
    } state_e;

    state_e state, state_nxt;
    cache_req_t os_req;
    logic live;
    logic [ways_w-1:0] victim;
    logic ar_done, aw_done, w_done, refill_err;
    logic [offset_w-1:0] refill_cnt;

    logic accept, want_ar, want_wr;
    logic os_read, os_store, os_cacheable;
    logic r_beat, b_beat, refill_bad, refill_ok;
    logic [1:0] fault;

    //////////////////////////////
    // Decode of the output stage
    //////////////////////////////
    assign os_read = os_req.cmd inside {cmd_load, cmd_execute};
    assign os_store = os_req.cmd == cmd_store;
    assign os_cacheable = os_req.address[cacheable_bit];
    assign fault = os_read ? load_fault : store_fault;

    assign r_ready = state inside {st_refill, st_bypass_read};
    assign b_ready = state == st_write && aw_done && w_done;
    assign r_beat = r_valid && r_ready;
    assign b_beat = b_valid && b_ready;
    assign refill_bad = refill_err || r.resp != axi_okay;
    assign refill_ok = state == st_refill && r_beat && r.last && !refill_bad;

    //////////////////////////////
    // FSM
    //////////////////////////////
    always_comb begin
        state_nxt = state;
        c_resp = resp_wait;
        want_ar = 1'b0;
        want_wr = 1'b0;
        tag_write = 1'b0;
        data_write = 1'b0;
        invalidate_all = 1'b0;
        case (state)
            st_idle: c_resp = live ? resp_idle : resp_wait;
            st_lookup: begin
                if (os_req.cmd == cmd_flush_all) begin
                    c_resp = resp_done;
                    invalidate_all = 1'b1;
                end else if (!(os_read || os_store) || fault[0]) begin
                    c_resp = resp_unknown_type;
                end else if (fault[1]) begin
                    c_resp = resp_misaligned;
                end else if (os_store) begin
                    want_wr = 1'b1;
                    state_nxt = st_write;
                end else if (!os_cacheable) begin
                    want_ar = 1'b1;
                    state_nxt = st_bypass_read;
                end else if (hit) begin
                    c_resp = resp_done;
                end else begin
                    want_ar = 1'b1;
                    state_nxt = st_refill;
                end
            end
            st_refill: begin
                want_ar = 1'b1;
                // Victim line is killed before its words are overwritten
                tag_write = (refill_cnt == '0 && !(r_beat && r.last)) || refill_ok;
                data_write = r_beat && !(r.last && refill_bad);
                if (r_beat && r.last) begin
                    if (refill_bad) begin
                        c_resp = resp_access_fault;
                    end else begin
                        state_nxt = st_replay;
                    end
                end
            end
            st_replay: state_nxt = st_lookup;
            st_bypass_read: begin
                want_ar = 1'b1;
                if (r_beat) begin
                    c_resp = (r.resp == axi_okay) ? resp_done : resp_access_fault;
                end
            end
            st_write: begin
                want_wr = 1'b1;
                if (b_beat) begin
                    // Cached copy is updated with the write response
                    data_write = hit && os_cacheable;
                    c_resp = (b.resp == axi_okay) ? resp_done : resp_access_fault;
                end
            end
            default: state_nxt = st_idle;
        endcase

        // Any final response frees the output stage for the next request
        accept = c_resp != resp_wait && c_req.cmd != cmd_none;
        if (c_resp != resp_wait) begin
            state_nxt = accept ? st_lookup : st_idle;
        end
    end

    //////////////////////////////
    // Memory port
    //////////////////////////////
    assign ar_valid = want_ar && !ar_done;
    assign ar = '{
        addr: os_cacheable ? {os_req.address[addr_w-1:offset_w+2], {(offset_w + 2){1'b0}}}
                           : os_req.address,
        len: os_cacheable ? refill_len : 8'd0
    };
    assign aw_valid = want_wr && !aw_done;
    assign aw = '{addr: os_req.address};
    assign w_valid = want_wr && !w_done;
    assign w = '{data: store_data, strb: store_strb};

    //////////////////////////////
    // Storage ports
    //////////////////////////////
    assign tag_read = accept || state == st_replay;
    assign data_read = tag_read;
    assign lane = accept ? c_req.address[lanes_w+offset_w+1:offset_w+2]
                         : os_req.address[lanes_w+offset_w+1:offset_w+2];
    assign data_lane = lane;
    assign data_offset = accept ? c_req.address[offset_w+1:2]
                       : (state == st_refill) ? refill_cnt : os_req.address[offset_w+1:2];
    assign tag_write_way = victim;
    // Tag with the cacheable bit cleared can never match a cached lookup
    assign os_tag = (state == st_refill && refill_cnt == '0)
                  ? {1'b0, os_req.address[addr_w-2:addr_w-tag_w]}
                  : os_req.address[addr_w-1:addr_w-tag_w];
    assign data_way = (state == st_refill) ? victim : hit_way;
    assign data_wdata = (state == st_refill) ? r.data : store_data;
    assign data_strb = (state == st_refill) ? 4'hf : store_strb;

    assign os_inword = os_req.address[1:0];
    assign os_load_type = os_req.load_type;
    assign os_store_type = os_req.store_type;
    assign os_store_data = os_req.store_data;
    assign load_word = (state == st_bypass_read) ? r.data : hit_rdata;

    always_ff @(posedge clk) begin
        if (accept) begin
            os_req <= c_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            live <= 1'b0;
            victim <= '0;
            ar_done <= 1'b0;
            aw_done <= 1'b0;
            w_done <= 1'b0;
            refill_err <= 1'b0;
            refill_cnt <= '0;
        end else begin
            state <= state_nxt;
            live <= 1'b1;
            if (refill_ok) begin
                victim <= victim + 1'b1;
            end
            ar_done <= !accept && (ar_done || (ar_valid && ar_ready));
            aw_done <= !accept && (aw_done || (aw_valid && aw_ready));
            w_done <= !accept && (w_done || (w_valid && w_ready));
            refill_err <= !accept && (refill_err || (r_beat && r.resp != axi_okay));
            if (accept) begin
                refill_cnt <= '0;
            end else if (r_beat && state == st_refill) begin
                refill_cnt <= refill_cnt + 1'b1;
            end
        end
    end

endmodule

//--- source/cache_top.sv
// Data cache top level joining the controller, tag and data stores and the aligners
`timescale 1ns/1ps

module cache_top (
    input logic clk,
    input logic rst_n,
    input cache_pkg::cache_req_t c_req,
    output cache_pkg::cache_resp_e c_resp,
    output logic [31:0] c_load_data,
    output logic ar_valid,
    input logic ar_ready,
    output cache_pkg::axi_ar_t ar,
    input logic r_valid,
    output logic r_ready,
    input cache_pkg::axi_r_t r,
    output logic aw_valid,
    input logic aw_ready,
    output cache_pkg::axi_aw_t aw,
    output logic w_valid,
    input logic w_ready,
    output cache_pkg::axi_w_t w,
    input logic b_valid,
    output logic b_ready,
    input cache_pkg::axi_b_t b
);
    import cache_pkg::*;

    logic tag_read, tag_write, invalidate_all, hit, data_read, data_write;
    logic [lanes_w-1:0] lane, data_lane;
    logic [offset_w-1:0] data_offset;
    logic [ways_w-1:0] tag_write_way, hit_way, data_way;
    logic [tag_w-1:0] os_tag;
    logic [31:0] data_wdata, hit_rdata, os_store_data, store_data, load_word;
    logic [3:0] data_strb, store_strb;
    logic [1:0] os_inword, load_fault, store_fault;
    load_type_e os_load_type;
    store_type_e os_store_type;

    cache_controller controller_i (.*);

    cache_tag_store tag_store_i (.*);

    cache_data_store data_store_i (.*);

    cache_load_align load_align_i (.*);

    cache_store_align store_align_i (.*);

endmodule

//--- testbench/tb_clock.sv
// Testbench clock and reset source with a 40 ns clock and a reset held for 5 cycles
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);
    localparam int period = 40;
    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Released on a rising edge, like a synchronous reset
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- testbench/tb_mem_model.sv
// AXI memory responder with address-derived data, write tracking and an error window
`timescale 1ns/1ps

module tb_mem_model (
    input logic clk,
    input logic rst_n,
    input logic ar_valid,
    output logic ar_ready,
    input cache_pkg::axi_ar_t ar,
    output logic r_valid,
    input logic r_ready,
    output cache_pkg::axi_r_t r,
    input logic aw_valid,
    output logic aw_ready,
    input cache_pkg::axi_aw_t aw,
    input logic w_valid,
    output logic w_ready,
    input cache_pkg::axi_w_t w,
    output logic b_valid,
    input logic b_ready,
    output cache_pkg::axi_b_t b
);
    import cache_pkg::*;

    int seed = 32'hb88c;
    logic [31:0] written [logic [31:0]];
    logic [31:0] rd_addr, wr_addr, merged;
    int beats_left;
    logic aw_seen, w_seen;
    axi_w_t wr_beat;

    // True on about three cycles in four
    function automatic logic coin();
        logic [31:0] v;
        v = $random(seed);
        return v[0] | v[1];
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] a);
        logic [31:0] wa;
        wa = {a[31:2], 2'b00};
        if (written.exists(wa)) begin
            return written[wa];
        end
        return wa ^ 32'h5a5a_0000;
    endfunction

    // Error window and its uncached alias
    function automatic axi_resp_e resp_at(input logic [31:0] a);
        return (a[30:8] == 23'h10_0000) ? axi_slverr : axi_okay;
    endfunction

    initial begin
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r = '0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        b = '0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            ar_ready <= 1'b0;
            r_valid <= 1'b0;
            aw_ready <= 1'b0;
            w_ready <= 1'b0;
            b_valid <= 1'b0;
            beats_left <= 0;
            aw_seen <= 1'b0;
            w_seen <= 1'b0;
        end else begin
            // One read burst at a time
            ar_ready <= beats_left == 0 && !(ar_valid && ar_ready) && coin();
            if (ar_valid && ar_ready) begin
                rd_addr <= {ar.addr[31:2], 2'b00};
                beats_left <= ar.len + 1;
            end
            // Read beats, with a gap after each one
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
                rd_addr <= rd_addr + 32'd4;
                beats_left <= beats_left - 1;
            end else if (!r_valid && beats_left > 0 && coin()) begin
                r_valid <= 1'b1;
                r <= '{data: word_at(rd_addr), resp: resp_at(rd_addr), last: beats_left == 1};
            end

            aw_ready <= !aw_seen && !(aw_valid && aw_ready) && coin();
            w_ready <= !w_seen && !(w_valid && w_ready) && coin();
            if (aw_valid && aw_ready) begin
                aw_seen <= 1'b1;
                wr_addr <= aw.addr;
            end
            if (w_valid && w_ready) begin
                w_seen <= 1'b1;
                wr_beat <= w;
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end else if (aw_seen && w_seen && !b_valid && coin()) begin
                b_valid <= 1'b1;
                b <= '{resp: resp_at(wr_addr)};
                aw_seen <= 1'b0;
                w_seen <= 1'b0;
                if (resp_at(wr_addr) == axi_okay) begin
                    merged = word_at(wr_addr);
                    for (int i = 0; i < 4; i++) begin
                        if (wr_beat.strb[i]) begin
                            merged[8*i +: 8] = wr_beat.data[8*i +: 8];
                        end
                    end
                    written[{wr_addr[31:2], 2'b00}] = merged;
                end
            end
        end
    end

endmodule

//--- testbench/tb_cache.sv
// Testbench top for the data cache with directed requests, bus assertions and a watchdog
`timescale 1ns/1ps

module tb_cache;
    import cache_pkg::*;

    localparam int n_tests = 6;
    localparam int n_refills = 8;
    localparam int timeout_cycles = n_tests * 200 + n_refills * 16 * 4;

    logic clk, rst_n;
    cache_req_t c_req;
    cache_resp_e c_resp;
    logic [31:0] c_load_data;
    logic ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
    logic w_valid, w_ready, b_valid, b_ready;
    axi_ar_t ar;
    axi_r_t r;
    axi_aw_t aw;
    axi_w_t w;
    axi_b_t b;

    // Expected bus traffic for the request in flight
    axi_ar_t exp_ar;
    axi_aw_t exp_aw;
    axi_w_t exp_w;
    logic allow_ar, allow_wr;

    int test_errs = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int ar_count = 0;
    int got_lat;
    cache_resp_e got_resp;
    logic [31:0] got_data;
    logic [31:0] shadow [logic [31:0]];

    tb_clock clock_i (.clk, .rst_n);
    tb_mem_model mem_i (.*);
    cache_top dut_i (.*);

    //////////////////////////////
    // Bus assertions
    //////////////////////////////
    ar_payload: assert property (@(negedge clk) disable iff (!rst_n) ar_valid |-> ar == exp_ar)
        else begin
            $display("error ar: expected %h, actual %h", exp_ar, ar);
            test_errs++;
        end
    aw_payload: assert property (@(negedge clk) disable iff (!rst_n) aw_valid |-> aw == exp_aw)
        else begin
            $display("error aw: expected %h, actual %h", exp_aw, aw);
            test_errs++;
        end
    w_payload: assert property (@(negedge clk) disable iff (!rst_n) w_valid |-> w == exp_w)
        else begin
            $display("error w: expected %h, actual %h", exp_w, w);
            test_errs++;
        end
    no_read: assert property (@(negedge clk) disable iff (!rst_n)
        !allow_ar |-> !(ar_valid || r_ready))
        else begin
            $display("A read channel was raised where no bus read was expected");
            test_errs++;
        end
    no_write: assert property (@(negedge clk) disable iff (!rst_n)
        !allow_wr |-> !(aw_valid || w_valid || b_ready))
        else begin
            $display("A write channel was raised where no bus write was expected");
            test_errs++;
        end
    b_after_wr: assert property (@(negedge clk) disable iff (!rst_n)
        b_ready |-> !(aw_valid || w_valid))
        else begin
            $display("The write response was accepted before address and data completed");
            test_errs++;
        end
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else begin
            $display("The read address changed or dropped before its handshake");
            test_errs++;
        end
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else begin
            $display("The write address changed or dropped before its handshake");
            test_errs++;
        end
    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else begin
            $display("The write data changed or dropped before its handshake");
            test_errs++;
        end

    always @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            ar_count <= ar_count + 1;
        end
    end

    //////////////////////////////
    // Reference rules
    //////////////////////////////
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return wa ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] extend(input logic [31:0] word, input logic [1:0] off,
                                           input load_type_e t);
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (t)
            load_lb: return {{24{sh[7]}}, sh[7:0]};
            load_lbu: return {24'h0, sh[7:0]};
            load_lh: return {{16{sh[15]}}, sh[15:0]};
            load_lhu: return {16'h0, sh[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic cache_req_t make_req(input cache_cmd_e cmd, input logic [31:0] addr,
                                            input load_type_e lt, input store_type_e st,
                                            input logic [31:0] d);
        return '{cmd: cmd, address: addr, load_type: lt, store_type: st, store_data: d};
    endfunction

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        value_check: assert (act === exp)
            else begin
                $display("error %s: expected %h, actual %h", name, exp, act);
                test_errs++;
            end
    endtask

    // One request at a time, measured from the accepting edge
    task automatic run_request(input cache_req_t req);
        c_req <= req;
        @(negedge clk);
        while (c_resp == resp_wait) begin
            @(negedge clk);
        end
        @(posedge clk);
        c_req <= '0;
        got_lat = 1;
        @(negedge clk);
        while (c_resp == resp_wait) begin
            @(negedge clk);
            got_lat++;
        end
        got_resp = c_resp;
        got_data = c_load_data;
        @(posedge clk);
    endtask

    task automatic load_and_check(input logic [31:0] addr, input load_type_e t,
                                  input cache_resp_e exp_resp, input int exp_ars);
        int ars_before;
        ars_before = ar_count;
        allow_ar = exp_ars > 0;
        allow_wr = 1'b0;
        exp_ar.addr = addr[31] ? {addr[31:6], 6'd0} : addr;
        exp_ar.len = addr[31] ? 8'd15 : 8'd0;
        run_request(make_req(cmd_load, addr, t, store_sw, 32'h0));
        expect_value("c_resp", exp_resp, got_resp);
        expect_value("ar count", exp_ars, ar_count - ars_before);
        if (exp_ars == 0) begin
            expect_value("latency", 1, got_lat);
        end
        if (exp_resp == resp_done) begin
            expect_value("c_load_data", extend(mem_word(addr), addr[1:0], t), got_data);
        end
    endtask

    task automatic store_and_check(input logic [31:0] addr, input store_type_e t,
                                   input logic [31:0] d, input cache_resp_e exp_resp);
        logic [31:0] merged;
        allow_ar = 1'b0;
        allow_wr = exp_resp == resp_done || exp_resp == resp_access_fault;
        case (t)
            store_sb: exp_w = '{data: {4{d[7:0]}}, strb: 4'b0001 << addr[1:0]};
            store_sh: exp_w = '{data: {2{d[15:0]}}, strb: addr[1] ? 4'b1100 : 4'b0011};
            default: exp_w = '{data: d, strb: 4'b1111};
        endcase
        exp_aw.addr = addr;
        run_request(make_req(cmd_store, addr, load_lw, t, d));
        expect_value("c_resp", exp_resp, got_resp);
        if (!allow_wr) begin
            expect_value("latency", 1, got_lat);
        end
        if (got_resp == resp_done) begin
            merged = mem_word(addr);
            for (int i = 0; i < 4; i++) begin
                if (exp_w.strb[i]) begin
                    merged[8*i +: 8] = exp_w.data[8*i +: 8];
                end
            end
            shadow[{addr[31:2], 2'b00}] = merged;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin
        c_req = '0;
        allow_ar = 1'b0;
        allow_wr = 1'b0;
        exp_ar = '0;
        exp_aw = '0;
        exp_w = '0;
        wait (rst_n);
        @(posedge clk);

        load_and_check(32'h8000_1048, load_lw, resp_done, 1);
        load_and_check(32'h8000_104c, load_lw, resp_done, 0);
        finish_test("refill_then_hit");

        for (int off = 0; off < 4; off++) begin
            load_and_check(32'h8000_1048 + off, load_lb, resp_done, 0);
            load_and_check(32'h8000_1048 + off, load_lbu, resp_done, 0);
            if (off % 2 == 0) begin
                load_and_check(32'h8000_1048 + off, load_lh, resp_done, 0);
                load_and_check(32'h8000_1048 + off, load_lhu, resp_done, 0);
            end
        end
        finish_test("load_extension");

        // Hits update the cached copy, a miss leaves the line to the next refill
        store_and_check(32'h8000_1051, store_sb, 32'h0000_00c3, resp_done);
        store_and_check(32'h8000_1052, store_sh, 32'h0000_beef, resp_done);
        store_and_check(32'h8000_1054, store_sw, 32'h1357_9bdf, resp_done);
        load_and_check(32'h8000_1050, load_lw, resp_done, 0);
        load_and_check(32'h8000_1054, load_lw, resp_done, 0);
        store_and_check(32'h8000_2008, store_sh, 32'h0000_7e81, resp_done);
        load_and_check(32'h8000_2008, load_lw, resp_done, 1);
        finish_test("store_merge");

        load_and_check(32'h0000_0400, load_lw, resp_done, 1);
        load_and_check(32'h0000_0400, load_lw, resp_done, 1);
        load_and_check(32'h0000_0402, load_lh, resp_done, 1);
        load_and_check(32'h1000_0010, load_lw, resp_access_fault, 1);
        load_and_check(32'h9000_0020, load_lw, resp_access_fault, 1);
        load_and_check(32'h9000_0020, load_lw, resp_access_fault, 1);
        finish_test("uncached_and_faults");

        load_and_check(32'h8000_1049, load_lh, resp_misaligned, 0);
        load_and_check(32'h8000_104a, load_lw, resp_misaligned, 0);
        load_and_check(32'h8000_1048, load_type_e'(3'd6), resp_unknown_type, 0);
        store_and_check(32'h8000_1053, store_sh, 32'h0000_0001, resp_misaligned);
        store_and_check(32'h8000_1052, store_sw, 32'h0000_0002, resp_misaligned);
        store_and_check(32'h8000_1050, store_type_e'(2'd3), 32'h0000_0003, resp_unknown_type);
        finish_test("bad_access");

        allow_ar = 1'b0;
        allow_wr = 1'b0;
        run_request(make_req(cmd_flush_all, 32'h0, load_lw, store_sw, 32'h0));
        expect_value("c_resp", resp_done, got_resp);
        expect_value("latency", 1, got_lat);
        load_and_check(32'h8000_1048, load_lw, resp_done, 1);
        load_and_check(32'h8000_2008, load_lw, resp_done, 1);
        finish_test("flush_all");

        $display("tests passed: %0d, failed: %0d", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- compile.f
source/cache_pkg.sv
source/cache_tag_store.sv
source/cache_data_store.sv
source/cache_load_align.sv
source/cache_store_align.sv
source/cache_controller.sv
source/cache_top.sv
testbench/tb_clock.sv
testbench/tb_mem_model.sv
testbench/tb_cache.sv

//--- Bender.yml
package:
  name: cache

sources:
  - source/cache_pkg.sv
  - source/cache_tag_store.sv
  - source/cache_data_store.sv
  - source/cache_load_align.sv
  - source/cache_store_align.sv
  - source/cache_controller.sv
  - source/cache_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_mem_model.sv
      - testbench/tb_cache.sv
